//--- uart_cfg_pkg.sv
package uart_cfg_pkg;

  // Bit-period counter wide enough for slow baud rates
  typedef logic [15:0] baud_cnt_t;

  // Clock cycles per serial bit
  // 434 gives 115200 baud from a 50 MHz clock
  localparam baud_cnt_t BIT_CYCLES = 16'd16;

  // Mid-bit sampling point
  localparam baud_cnt_t HALF_BIT = BIT_CYCLES >> 1;

  localparam int DATA_BITS = 8;

  // Start bit, data bits, parity bit, stop bit
  localparam int FRAME_BITS = DATA_BITS + 3;

  // Idle bit times between the two bytes of a write
  localparam int GAP_BITS = 15;

  localparam baud_cnt_t GAP_CYCLES = baud_cnt_t'(GAP_BITS * BIT_CYCLES);

endpackage

//--- uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int CMD_WIDTH = 16;

  // Set for a write, clear for a read
  localparam int RW_BIT = 15;

  typedef logic [CMD_WIDTH-1:0] cmd_t;

  typedef logic [7:0] byte_t;

  // Operation carried in the command's top bit
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef enum logic [3:0]
  {
    IDLE,
    RW_JUDGE,
    SEND_HI,
    WAIT_HI,
    GAP,
    SEND_LO,
    WAIT_LO,
    RECV_REPLY,
    DELIVER
  } cmd_state_e;

endpackage

//--- uart_byte_if.sv
`timescale 1ns/1ps

// Byte hand-off from the controller to the transmit framer
interface uart_tx_if import uart_cmd_pkg::*; ();

  logic  start;
  byte_t data;
  logic  busy;
  logic  done;

  modport ctrl
  (
    output start,
    output data,
    input  busy,
    input  done
  );

  modport framer
  (
    input  start,
    input  data,
    output busy,
    output done
  );

endinterface

// Reply byte from the receive framer back to the controller
interface uart_rx_if import uart_cmd_pkg::*; ();

  logic  arm;
  byte_t data;
  logic  valid;
  logic  parity_err;

  modport ctrl
  (
    output arm,
    input  data,
    input  valid,
    input  parity_err
  );

  modport framer
  (
    input  arm,
    output data,
    output valid,
    output parity_err
  );

endinterface

//--- uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame import uart_cfg_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  uart_tx_if.framer bus,
  output logic    tx
);

  logic                 busy;
  baud_cnt_t            baud_cnt;
  logic [3:0]           bit_idx;
  // Data bits, parity and stop still to go out
  logic [DATA_BITS+1:0] shreg;
  logic                 bit_end;
  logic                 last_bit;

  assign bit_end  = (baud_cnt == BIT_CYCLES - 1'b1);
  assign last_bit = (bit_idx == FRAME_BITS - 1);

  assign bus.busy = busy;
  assign bus.done = busy && bit_end && last_bit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!busy)
    begin
      if (bus.start)
      begin
        // Start bit goes out right away
        busy     <= 1'b1;
        tx       <= 1'b0;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (last_bit)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        tx      <= shreg[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Even parity over the data byte
  always_ff @(posedge clk)
  begin
    if (!busy && bus.start)
      shreg <= {1'b1, ^bus.data, bus.data};
    else if (busy && bit_end)
      shreg <= shreg >> 1;
  end

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    bus.start |-> !busy);

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> tx);

endmodule

//--- uart_rx_frame.sv
`timescale 1ns/1ps

module uart_rx_frame import uart_cfg_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    rx,
  uart_rx_if.framer bus
);

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 fall;
  logic                 active;
  baud_cnt_t            baud_cnt;
  logic [3:0]           bit_idx;
  logic                 sample;
  logic [DATA_BITS-1:0] data_q;
  logic                 par_q;
  logic                 valid_q;
  logic                 perr_q;

  assign fall   = rx_prev && !rx_sync;
  assign sample = active && (baud_cnt == BIT_CYCLES - 1'b1);

  assign bus.data       = data_q;
  assign bus.valid      = valid_q;
  assign bus.parity_err = perr_q;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      valid_q  <= 1'b0;
      perr_q   <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      perr_q  <= 1'b0;
      if (!active)
      begin
        if (bus.arm && fall)
        begin
          // First sample lands half a bit after the edge
          active   <= 1'b1;
          baud_cnt <= BIT_CYCLES - HALF_BIT - 1'b1;
          bit_idx  <= '0;
        end
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == 4'd0 && rx_sync)
        begin
          // Glitch rather than a real start bit
          active <= 1'b0;
        end
        else if (bit_idx == FRAME_BITS - 1)
        begin
          active  <= 1'b0;
          valid_q <= (par_q == ^data_q);
          perr_q  <= (par_q != ^data_q);
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // LSB arrives first
  always_ff @(posedge clk)
  begin
    if (sample && bit_idx >= 4'd1 && bit_idx <= DATA_BITS)
      data_q <= {rx_sync, data_q[DATA_BITS-1:1]};
    if (sample && bit_idx == DATA_BITS + 1)
      par_q <= rx_sync;
  end

  a_result_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus.valid && bus.parity_err));

endmodule

//--- uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl import uart_cfg_pkg::*, uart_cmd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  output logic  read_rdy,
  output byte_t read_data,
  output logic  read_err,
  uart_tx_if.ctrl txb,
  uart_rx_if.ctrl rxb
);

  cmd_state_e state;
  cmd_state_e next_state;
  cmd_t       cmd_buf;
  cmd_op_e    op;
  baud_cnt_t  gap_cnt;
  logic       reply_end;

  assign reply_end = (state == RECV_REPLY) && (rxb.valid || rxb.parity_err);

  assign cmd_rdy = (state == IDLE);
  assign rxb.arm = (state == RECV_REPLY);

  // Launch a frame only once the framer has gone idle
  assign txb.start = (state == SEND_HI || state == SEND_LO) && !txb.busy;
  assign txb.data  = (state == SEND_LO) ? cmd_buf[$bits(byte_t)-1:0]
                                        : cmd_buf[CMD_WIDTH-1 -: $bits(byte_t)];

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
        if (cmd_vld)
          next_state = RW_JUDGE;
      RW_JUDGE:
        next_state = SEND_HI;
      SEND_HI:
        if (!txb.busy)
          next_state = WAIT_HI;
      WAIT_HI:
        if (txb.done)
          next_state = (op == OP_WRITE) ? GAP : RECV_REPLY;
      GAP:
        if (gap_cnt == GAP_CYCLES - 1'b1)
          next_state = SEND_LO;
      SEND_LO:
        if (!txb.busy)
          next_state = WAIT_LO;
      WAIT_LO:
        if (txb.done)
          next_state = IDLE;
      RECV_REPLY:
        if (rxb.valid || rxb.parity_err)
          next_state = DELIVER;
      DELIVER:
        next_state = IDLE;
      default:
        next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= next_state;
  end

  // Operation decoded once per command
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      op <= OP_READ;
    else if (state == RW_JUDGE)
      op <= cmd_op_e'(cmd_buf[RW_BIT]);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      gap_cnt <= '0;
    else if (state == GAP)
      gap_cnt <= gap_cnt + 1'b1;
    else
      gap_cnt <= '0;
  end

  // Result strobes land in DELIVER
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      read_rdy <= (state == RECV_REPLY) && rxb.valid;
      read_err <= (state == RECV_REPLY) && rxb.parity_err;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && cmd_vld)
      cmd_buf <= cmd_in;
    if (reply_end)
      read_data <= rxb.data;
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {IDLE, RW_JUDGE, SEND_HI, WAIT_HI, GAP, SEND_LO, WAIT_LO,
                  RECV_REPLY, DELIVER});

  a_read_result_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_rdy && read_err));

endmodule

//--- uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top import uart_cmd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  input  logic  rx,
  output logic  tx,
  output logic  cmd_rdy,
  output logic  read_rdy,
  output byte_t read_data,
  output logic  read_err
);

  uart_tx_if tx_bus ();
  uart_rx_if rx_bus ();

  uart_cmd_ctrl ctrl_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err),
    .txb       (tx_bus.ctrl),
    .rxb       (rx_bus.ctrl)
  );

  uart_tx_frame tx_frame_i
  (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (tx_bus.framer),
    .tx    (tx)
  );

  uart_rx_frame rx_frame_i
  (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .bus   (rx_bus.framer)
  );

endmodule

//--- tb_uart_cmd.sv
`timescale 1ns/1ps

module tb_uart_cmd
  import uart_cfg_pkg::*, uart_cmd_pkg::*;
();

  localparam int NUM_ENTRIES = 8;
  localparam int TIMEOUT_CYCLES =
    NUM_ENTRIES * (2 * FRAME_BITS + GAP_BITS + FRAME_BITS) * BIT_CYCLES * 2;

  logic  clk;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  rx;
  logic  tx;
  logic  cmd_rdy;
  logic  read_rdy;
  byte_t read_data;
  logic  read_err;

  // Stimulus table
  cmd_t  cmd_tab   [NUM_ENTRIES];
  byte_t reply_tab [NUM_ENTRIES];
  logic  bad_tab   [NUM_ENTRIES];

  // Frames seen on tx
  byte_t       frame_byte  [$];
  logic        frame_par   [$];
  logic        frame_stop  [$];
  int unsigned frame_start [$];
  int unsigned starts_seen;

  int unsigned cycle = 0;
  int unsigned rdy_cnt;
  int unsigned err_cnt;
  byte_t       got_data;
  int unsigned errors = 0;

  uart_cmd_top dut_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      errors++;
      $display("mismatch at %0t ns: %s, expected %0h, got %0h",
               $time, what, expected, actual);
    end
  endtask

  // Serial line monitor sampling tx at mid-bit on falling clock edges
  initial
  begin : tx_monitor
    byte_t       b;
    logic        p;
    logic        s;
    int unsigned t0;
    forever
    begin
      @(negedge clk);
      if (rst_n && tx === 1'b0)
      begin
        t0 = cycle;
        starts_seen++;
        repeat (HALF_BIT) @(negedge clk);
        for (int k = 0; k < DATA_BITS; k++)
        begin
          repeat (BIT_CYCLES) @(negedge clk);
          b[k] = tx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        p = tx;
        repeat (BIT_CYCLES) @(negedge clk);
        s = tx;
        frame_byte.push_back(b);
        frame_par.push_back(p);
        frame_stop.push_back(s);
        frame_start.push_back(t0);
      end
    end
  end

  // Read result strobes
  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      rdy_cnt++;
      got_data = read_data;
    end
    if (rst_n && read_err)
      err_cnt++;
  end

  // Reply frame onto rx with the parity flipped on request
  task automatic drive_reply(input byte_t data, input logic bad);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, (^data) ^ bad, data, 1'b0};
    for (int k = 0; k < FRAME_BITS; k++)
    begin
      rx = frame[k];
      repeat (BIT_CYCLES) @(posedge clk);
      #1;
    end
    rx = 1'b1;
  endtask

  task automatic wait_cmd_rdy();
    do
    begin
      @(posedge clk);
      #1;
    end
    while (cmd_rdy !== 1'b1);
  endtask

  task automatic pulse_cmd(input cmd_t c);
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  initial
  begin : timeout_guard
    while (cycle < TIMEOUT_CYCLES)
      @(posedge clk);
    $display("Timeout: run passed %0d cycles before the test table finished",
             TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin : main
    logic [31:0] rnd;
    int unsigned errs_before;
    int          idle;
    int          pass_cnt;
    int          fail_cnt;
    logic        is_write;
    pass_cnt = 0;
    fail_cnt = 0;
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    rx       = 1'b1;
    starts_seen = 0;
    rdy_cnt  = 0;
    err_cnt  = 0;

    cmd_tab[0] = 16'h8a5c; reply_tab[0] = 8'h00; bad_tab[0] = 1'b0;
    cmd_tab[1] = 16'h1200; reply_tab[1] = 8'h3c; bad_tab[1] = 1'b0;
    cmd_tab[2] = 16'h7f00; reply_tab[2] = 8'ha5; bad_tab[2] = 1'b1;
    cmd_tab[3] = 16'hff01; reply_tab[3] = 8'h00; bad_tab[3] = 1'b0;
    rnd = 32'h27d7;
    for (int i = 4; i < NUM_ENTRIES; i++)
    begin
      rnd          = xorshift32(rnd);
      cmd_tab[i]   = rnd[15:0];
      reply_tab[i] = rnd[23:16];
      bad_tab[i]   = rnd[24];
    end

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("tx after reset", tx, 1'b1);
    check_value("cmd_rdy after reset", cmd_rdy, 1'b1);
    check_value("read_rdy after reset", read_rdy, 1'b0);
    check_value("read_err after reset", read_err, 1'b0);
    $display("reset state: %s", (errors == 0) ? "ok" : "failed");

    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      wait_cmd_rdy();
      errs_before = errors;
      is_write    = cmd_tab[i][RW_BIT];
      frame_byte.delete();
      frame_par.delete();
      frame_stop.delete();
      frame_start.delete();
      starts_seen = 0;
      rdy_cnt     = 0;
      err_cnt     = 0;
      pulse_cmd(cmd_tab[i]);

      // A command while busy must be dropped
      repeat (20) @(posedge clk);
      #1;
      check_value("cmd_rdy low while busy", cmd_rdy, 1'b0);
      pulse_cmd(~cmd_tab[i]);

      if (!is_write)
      begin
        while (frame_byte.size() < 1)
        begin
          @(posedge clk);
          #1;
        end
        repeat (BIT_CYCLES + 3 * i) @(posedge clk);
        #1;
        drive_reply(reply_tab[i], bad_tab[i]);
      end

      wait_cmd_rdy();
      check_value("frames done at cmd_rdy", frame_byte.size(), is_write ? 2 : 1);
      repeat (2 * BIT_CYCLES) @(posedge clk);
      #1;
      check_value("frame starts on tx", starts_seen, is_write ? 2 : 1);

      if (frame_byte.size() >= 1)
      begin
        check_value("high byte", frame_byte[0], cmd_tab[i][15:8]);
        check_value("high byte parity", frame_par[0], ^cmd_tab[i][15:8]);
        check_value("high byte stop bit", frame_stop[0], 1'b1);
      end
      if (is_write && frame_byte.size() >= 2)
      begin
        check_value("low byte", frame_byte[1], cmd_tab[i][7:0]);
        check_value("low byte parity", frame_par[1], ^cmd_tab[i][7:0]);
        check_value("low byte stop bit", frame_stop[1], 1'b1);
        idle = int'(frame_start[1]) - int'(frame_start[0]) - FRAME_BITS * int'(BIT_CYCLES);
        check_value("write gap length", idle >= GAP_BITS * int'(BIT_CYCLES), 1'b1);
      end

      if (is_write || bad_tab[i])
        check_value("read_rdy pulses", rdy_cnt, 0);
      else
        check_value("read_rdy pulses", rdy_cnt, 1);
      check_value("read_err pulses", err_cnt, (!is_write && bad_tab[i]) ? 1 : 0);
      if (!is_write && !bad_tab[i])
        check_value("read_data", got_data, reply_tab[i]);

      if (errors == errs_before)
        pass_cnt++;
      else
        fail_cnt++;
      $display("entry %0d cmd %h %s: %s", i, cmd_tab[i],
               is_write ? "write" : (bad_tab[i] ? "read bad parity" : "read"),
               (errors == errs_before) ? "ok" : "failed");
    end

    $display("%0d entries passed, %0d entries failed, %0d mismatches",
             pass_cnt, fail_cnt, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- uart_cmd.f
uart_cfg_pkg.sv
uart_cmd_pkg.sv
uart_byte_if.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_cmd_ctrl.sv
uart_cmd_top.sv
tb_uart_cmd.sv
